// ==== mhq_alloc.sv ====
// Lookup across miss entries, merge-or-allocate choice and acceptance of load/store requests
`timescale 1ns/10ps
`default_nettype none

module mhq_alloc (
    input  logic                          i_lsu_valid,
    input  mhq_pkg::lsu_req_t             i_lsu_req,

    // Per-entry status, bit i belongs to entry i
    input  logic [mhq_pkg::MHQ_DEPTH-1:0] i_hits,
    input  logic [mhq_pkg::MHQ_DEPTH-1:0] i_valids,
    input  logic [mhq_pkg::MHQ_DEPTH-1:0] i_launching,

    output logic                          o_lsu_ready,
    output logic [mhq_pkg::MHQ_DEPTH-1:0] o_update_en,
    output mhq_pkg::lsu_req_t             o_update
);

    import mhq_pkg::*;

    logic                 hit_any;
    logic                 hit_launching;
    logic                 full;
    logic                 accept;
    logic [MHQ_DEPTH-1:0] free_onehot;

    // Entries never hold the same line twice, so at most one hit bit is set
    assign hit_any       = |i_hits;
    assign hit_launching = |(i_hits & i_launching);
    assign full          = &i_valids;

    // Lowest free slot, scanning from the top so the lowest index wins
    always_comb begin
        free_onehot = '0;
        for (int i = MHQ_DEPTH - 1; i >= 0; i--) begin
            if (!i_valids[i]) begin
                free_onehot    = '0;
                free_onehot[i] = 1'b1;
            end
        end
    end

    // A hit merges unless that line sits on the fill port, where a merge
    // would change a payload that is already on offer
    // Without a hit the request needs a free slot
    always_comb begin
        if (hit_any) begin
            o_lsu_ready = ~hit_launching;
        end else begin
            o_lsu_ready = ~full;
        end
    end

    assign accept = i_lsu_valid & o_lsu_ready;

    always_comb begin
        o_update_en = '0;
        if (accept) begin
            o_update_en = hit_any ? i_hits : free_onehot;
        end
    end

    // Every entry sees the same request and only the enabled one takes it
    assign o_update = i_lsu_req;

endmodule

`default_nettype wire

// ==== mhq_assert.sv ====
// Bound assertions for handshake payload stability, refusal release and the idle state after reset
`timescale 1ns/10ps
`default_nettype none

module mhq_assert (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_lsu_valid,
    input  logic                o_lsu_ready,
    input  logic                o_ccu_req_valid,
    input  mhq_pkg::ccu_req_t   o_ccu_req,
    input  logic                i_ccu_req_ready,
    input  logic                o_fill_valid,
    input  mhq_pkg::fill_t      o_fill,
    input  logic                i_fill_ready
);

    // A read that the CCU holds back stays on the port unchanged
    ccu_req_stable: assert property (@(posedge clk) disable iff (i_reset)
        o_ccu_req_valid && !i_ccu_req_ready |=> o_ccu_req_valid && $stable(o_ccu_req))
        else $error("CCU request changed or dropped before the CCU took it");

    // A fill under back-pressure keeps its line, address and dirty flag
    fill_stable: assert property (@(posedge clk) disable iff (i_reset)
        o_fill_valid && !i_fill_ready |=> o_fill_valid && $stable(o_fill))
        else $error("Fill payload changed or dropped before the cache took it");

    // A transferred fill frees its entry, so a refused request gets in on the next cycle
    lsu_freed_by_fill: assert property (@(posedge clk) disable iff (i_reset)
        i_lsu_valid && !o_lsu_ready && o_fill_valid && i_fill_ready |=> o_lsu_ready)
        else $error("LSU request still refused after a fill transferred");

    // Nothing is on offer and a request can enter one cycle after reset
    reset_idle: assert property (@(posedge clk)
        i_reset |=> !o_ccu_req_valid && !o_fill_valid && o_lsu_ready)
        else $error("Queue not idle after reset");

endmodule

bind mhq_top mhq_assert u_mhq_assert (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_lsu_valid     (i_lsu_valid),
    .o_lsu_ready     (o_lsu_ready),
    .o_ccu_req_valid (o_ccu_req_valid),
    .o_ccu_req       (o_ccu_req),
    .i_ccu_req_ready (i_ccu_req_ready),
    .o_fill_valid    (o_fill_valid),
    .o_fill          (o_fill),
    .i_fill_ready    (i_fill_ready)
);

`default_nettype wire

// ==== mhq_ccu_req.sv ====
// CCU read request issue: one read per allocated line, held stable until the CCU takes it
`timescale 1ns/10ps
`default_nettype none

module mhq_ccu_req (
    input  logic                                            clk,
    input  logic                                            i_reset,

    input  mhq_pkg::mhq_entry_t [mhq_pkg::MHQ_DEPTH-1:0]    i_entries,

    input  logic                                            i_ccu_req_ready,
    output logic                                            o_ccu_req_valid,
    output mhq_pkg::ccu_req_t                               o_ccu_req
);

    import mhq_pkg::*;

    // Set once the read for an entry has gone out
    logic [MHQ_DEPTH-1:0]     sent_r;
    logic [MHQ_DEPTH-1:0]     pending;
    logic [MHQ_IDX_WIDTH-1:0] pick_idx;
    logic [MHQ_IDX_WIDTH-1:0] sel_idx;
    logic                     locked_r;
    logic [MHQ_IDX_WIDTH-1:0] locked_idx_r;
    logic                     transfer;

    // An entry still needs a read while it waits for data and none was sent
    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            pending[i] = i_entries[i].valid & ~i_entries[i].complete & ~sent_r[i];
        end
    end

    always_comb begin
        pick_idx = '0;
        for (int i = MHQ_DEPTH - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_idx = MHQ_IDX_WIDTH'(i);
            end
        end
    end

    // Once offered, the same entry stays on the port even if a lower
    // index becomes pending in the meantime
    assign sel_idx         = locked_r ? locked_idx_r : pick_idx;
    assign o_ccu_req_valid = locked_r | (|pending);
    assign o_ccu_req.idx   = sel_idx;
    assign o_ccu_req.addr  = i_entries[sel_idx].addr;
    assign transfer        = o_ccu_req_valid & i_ccu_req_ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            locked_r <= 1'b0;
        end else if (transfer) begin
            locked_r <= 1'b0;
        end else if (o_ccu_req_valid) begin
            locked_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ccu_req_valid && !locked_r) begin
            locked_idx_r <= pick_idx;
        end
    end

    // A freed slot forgets its read so the next line in it gets its own
    always_ff @(posedge clk) begin
        if (i_reset) begin
            sent_r <= '0;
        end else begin
            for (int i = 0; i < MHQ_DEPTH; i++) begin
                if (!i_entries[i].valid) begin
                    sent_r[i] <= 1'b0;
                end else if (transfer && (sel_idx == MHQ_IDX_WIDTH'(i))) begin
                    sent_r[i] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== mhq_entry.sv ====
// Miss queue entry with its state machine, line address match and byte-merging line buffer
`timescale 1ns/10ps
`default_nettype none

module mhq_entry (
    input  logic                                clk,
    input  logic                                i_reset,

    // Allocate into or merge with this entry
    input  logic                                i_update_en,
    input  mhq_pkg::lsu_req_t                   i_update,

    // Line data from the CCU, done is a one-cycle pulse
    input  logic                                i_ccu_done,
    input  logic [mhq_pkg::LINE_WIDTH-1:0]      i_ccu_data,

    // The fill for this entry transferred in this cycle
    input  logic                                i_fill_launched,

    // Address compare against the request being offered
    input  logic [mhq_pkg::LINE_ADDR_WIDTH-1:0] i_lookup_addr,
    output logic                                o_lookup_hit,

    output mhq_pkg::mhq_entry_t                 o_entry
);

    import mhq_pkg::*;

    mhq_state_e                 state_r;
    mhq_state_e                 state_next;
    logic                       dirty_r;
    logic [LINE_ADDR_WIDTH-1:0] addr_r;
    logic [LINE_WIDTH-1:0]      data_r;
    // A set bit means a store owns that byte and the CCU copy must not replace it
    logic [LINE_SIZE-1:0]       byte_updated_r;

    logic                       entry_valid;
    logic                       allocating;
    logic [LINE_SIZE-1:0]       store_bytes;
    logic [LINE_WIDTH-1:0]      data_next;
    logic [LINE_SIZE-1:0]       byte_updated_next;

    assign entry_valid = (state_r != STATE_INVALID);

    // An update to a free slot starts a new line, otherwise it merges
    assign allocating = i_update_en & ~entry_valid;

    // Bytes that the current request writes, loads write none
    assign store_bytes = {LINE_SIZE{i_update_en & i_update.we}} & i_update.byte_sel;

    always_comb begin
        state_next = state_r;
        case (state_r)
            STATE_INVALID: begin
                if (i_update_en) begin
                    state_next = STATE_VALID;
                end
            end
            STATE_VALID: begin
                if (i_ccu_done) begin
                    state_next = STATE_COMPLETE;
                end
            end
            STATE_COMPLETE: begin
                if (i_fill_launched) begin
                    state_next = STATE_INVALID;
                end
            end
            default: begin
                state_next = STATE_INVALID;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= STATE_INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Store bytes go in first and are marked as owned
    // CCU bytes then fill only what no store has written, so a store wins
    // whether it came before the response or in the same cycle
    always_comb begin
        data_next         = data_r;
        byte_updated_next = allocating ? '0 : byte_updated_r;
        for (int i = 0; i < LINE_SIZE; i++) begin
            if (store_bytes[i]) begin
                data_next[i*8 +: 8]  = i_update.data[i*8 +: 8];
                byte_updated_next[i] = 1'b1;
            end else if (i_ccu_done && !byte_updated_next[i]) begin
                data_next[i*8 +: 8] = i_ccu_data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        // A fresh line is dirty only if its first request is a store
        if (i_update_en) begin
            dirty_r <= i_update.we | (~allocating & dirty_r);
        end
        if (allocating) begin
            addr_r <= i_update.addr;
        end
        data_r         <= data_next;
        byte_updated_r <= byte_updated_next;
    end

    assign o_lookup_hit = entry_valid && (addr_r == i_lookup_addr);

    assign o_entry.valid    = entry_valid;
    assign o_entry.complete = (state_r == STATE_COMPLETE);
    assign o_entry.dirty    = dirty_r;
    assign o_entry.addr     = addr_r;
    assign o_entry.data     = data_r;

endmodule

`default_nettype wire

// ==== mhq_fill.sv ====
// Cache fill launch: picks a complete entry, holds it on the fill port and marks its transfer
`timescale 1ns/10ps
`default_nettype none

module mhq_fill (
    input  logic                                            clk,
    input  logic                                            i_reset,

    input  mhq_pkg::mhq_entry_t [mhq_pkg::MHQ_DEPTH-1:0]    i_entries,

    input  logic                                            i_fill_ready,
    output logic                                            o_fill_valid,
    output mhq_pkg::fill_t                                  o_fill,

    // Entry on the fill port this cycle, and entry whose fill transferred
    output logic [mhq_pkg::MHQ_DEPTH-1:0]                   o_launching,
    output logic [mhq_pkg::MHQ_DEPTH-1:0]                   o_launched
);

    import mhq_pkg::*;

    logic [MHQ_DEPTH-1:0]     complete;
    logic [MHQ_IDX_WIDTH-1:0] pick_idx;
    logic [MHQ_IDX_WIDTH-1:0] sel_idx;
    logic [MHQ_DEPTH-1:0]     sel_onehot;
    logic                     locked_r;
    logic [MHQ_IDX_WIDTH-1:0] locked_idx_r;
    logic                     transfer;

    always_comb begin
        pick_idx = '0;
        for (int i = MHQ_DEPTH - 1; i >= 0; i--) begin
            complete[i] = i_entries[i].complete;
            if (i_entries[i].complete) begin
                pick_idx = MHQ_IDX_WIDTH'(i);
            end
        end
    end

    // The first complete entry is offered in the cycle it turns complete,
    // later cycles keep the locked one until the cache takes it
    assign sel_idx      = locked_r ? locked_idx_r : pick_idx;
    assign o_fill_valid = locked_r | (|complete);
    assign transfer     = o_fill_valid & i_fill_ready;

    assign o_fill.dirty = i_entries[sel_idx].dirty;
    assign o_fill.addr  = i_entries[sel_idx].addr;
    assign o_fill.data  = i_entries[sel_idx].data;

    always_comb begin
        sel_onehot          = '0;
        sel_onehot[sel_idx] = 1'b1;
    end

    assign o_launching = o_fill_valid ? sel_onehot : '0;
    assign o_launched  = transfer ? sel_onehot : '0;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            locked_r <= 1'b0;
        end else if (transfer) begin
            locked_r <= 1'b0;
        end else if (o_fill_valid) begin
            locked_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_fill_valid && !locked_r) begin
            locked_idx_r <= pick_idx;
        end
    end

endmodule

`default_nettype wire

// ==== mhq_pkg.sv ====
// Miss handling queue sizes, entry state enum and request, entry, CCU and fill structs
`default_nettype none

package mhq_pkg;

    // Number of miss entries and the width of an index that selects one
    localparam int MHQ_DEPTH     = 4;
    localparam int MHQ_IDX_WIDTH = $clog2(MHQ_DEPTH);

    // Byte address and cache line geometry
    localparam int ADDR_WIDTH      = 32;
    localparam int LINE_SIZE       = 32;
    localparam int LINE_WIDTH      = LINE_SIZE * 8;
    localparam int OFFSET_WIDTH    = $clog2(LINE_SIZE);
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

    // Life of an entry
    // INVALID means the slot is free
    // VALID means a line is tracked and the CCU has not answered yet
    // COMPLETE means the line is whole and waits to be sent out as a fill
    typedef enum logic [1:0] {
        STATE_INVALID  = 2'b00,
        STATE_VALID    = 2'b01,
        STATE_COMPLETE = 2'b10
    } mhq_state_e;

    // One miss from the load/store unit, the write flag marks a store
    // Byte select picks which bytes of the data field a store writes
    typedef struct packed {
        logic                       we;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
        logic [LINE_SIZE-1:0]       byte_sel;
    } lsu_req_t;

    // What an entry shows to the lookup, CCU and fill logic
    typedef struct packed {
        logic                       valid;
        logic                       complete;
        logic                       dirty;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
    } mhq_entry_t;

    // Line read sent to the CCU, tagged with the entry that waits for it
    typedef struct packed {
        logic [MHQ_IDX_WIDTH-1:0]   idx;
        logic [LINE_ADDR_WIDTH-1:0] addr;
    } ccu_req_t;

    // Whole line returned by the CCU, the index names the entry it belongs to
    typedef struct packed {
        logic [MHQ_IDX_WIDTH-1:0] idx;
        logic [LINE_WIDTH-1:0]    data;
    } ccu_rsp_t;

    // Finished line handed back to the cache
    typedef struct packed {
        logic                       dirty;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0]      data;
    } fill_t;

endpackage

`default_nettype wire

// ==== mhq_tb.sv ====
// Testbench with clock, reset, random LSU traffic, CCU responder, fill sink and line model
`timescale 1ns/10ps
`default_nettype none

module mhq_tb;

    import mhq_pkg::*;

    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

    localparam int NUM_REQUESTS   = 600;
    localparam int POOL_SIZE      = 6;
    localparam int SEED           = 23732;
    localparam int ACCEPT_TIMEOUT = 1000;
    localparam int DRAIN_TIMEOUT  = 4000;
    // Compare width covers a whole fill payload
    localparam int CMP_WIDTH      = 512;

    logic     clk;
    logic     i_reset;
    logic     i_lsu_valid;
    lsu_req_t i_lsu_req;
    logic     o_lsu_ready;
    logic     o_ccu_req_valid;
    ccu_req_t o_ccu_req;
    logic     i_ccu_req_ready;
    logic     i_ccu_rsp_valid;
    ccu_rsp_t i_ccu_rsp;
    logic     o_fill_valid;
    fill_t    o_fill;
    logic     i_fill_ready;

    // Reference model with one record per outstanding line address
    line_addr_t            pool [POOL_SIZE];
    logic [LINE_WIDTH-1:0] model_data [line_addr_t];
    logic                  model_dirty [line_addr_t];
    logic                  model_requested [line_addr_t];
    logic                  model_responded [line_addr_t];

    // CCU answers that wait for their due cycle in request order
    ccu_rsp_t              rsp_q [$];
    line_addr_t            rsp_addr_q [$];
    int                    rsp_due_q [$];

    int                    cycle;
    logic                  lsu_fire_seen;
    logic                  fill_hold;
    fill_t                 held_fill;
    int                    alloc_count;
    int                    ccu_count;
    int                    fill_count;
    int                    dirty_fill_count;
    int                    full_block_cycles;
    int                    late_store_count;

    always #5 clk = ~clk;

    mhq_top DUT (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_lsu_valid     (i_lsu_valid),
        .i_lsu_req       (i_lsu_req),
        .o_lsu_ready     (o_lsu_ready),
        .o_ccu_req_valid (o_ccu_req_valid),
        .o_ccu_req       (o_ccu_req),
        .i_ccu_req_ready (i_ccu_req_ready),
        .i_ccu_rsp_valid (i_ccu_rsp_valid),
        .i_ccu_rsp       (i_ccu_rsp),
        .o_fill_valid    (o_fill_valid),
        .o_fill          (o_fill),
        .i_fill_ready    (i_fill_ready)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [CMP_WIDTH-1:0] actual,
                               input logic [CMP_WIDTH-1:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // The CCU returns byte i of a line as the low line address byte plus i
    function automatic logic [LINE_WIDTH-1:0] ccu_pattern(input line_addr_t addr);
        logic [LINE_WIDTH-1:0] line;
        for (int i = 0; i < LINE_SIZE; i++) begin
            line[i*8 +: 8] = addr[7:0] + 8'(i);
        end
        return line;
    endfunction

    function automatic lsu_req_t random_request();
        lsu_req_t req;
        req.we   = ($urandom_range(9, 0) < 4);
        req.addr = pool[$urandom_range(POOL_SIZE - 1, 0)];
        for (int w = 0; w < LINE_WIDTH / 32; w++) begin
            req.data[w*32 +: 32] = $urandom();
        end
        // Sparse byte selects leave room for later stores to overlap earlier ones
        req.byte_sel = $urandom() & $urandom();
        return req;
    endfunction

    // A hit is taken unless that line sits on the fill port
    // A miss needs a free slot
    function automatic logic expected_ready(input line_addr_t addr);
        if (model_data.exists(addr)) begin
            return !(o_fill_valid && (o_fill.addr == addr));
        end
        return (model_data.num() < MHQ_DEPTH);
    endfunction

    task automatic apply_request(input lsu_req_t req);
        logic [LINE_WIDTH-1:0] line;
        if (!model_data.exists(req.addr)) begin
            model_data[req.addr]      = ccu_pattern(req.addr);
            model_dirty[req.addr]     = 1'b0;
            model_requested[req.addr] = 1'b0;
            alloc_count++;
        end
        if (req.we) begin
            line = model_data[req.addr];
            for (int i = 0; i < LINE_SIZE; i++) begin
                if (req.byte_sel[i]) begin
                    line[i*8 +: 8] = req.data[i*8 +: 8];
                end
            end
            model_data[req.addr]  = line;
            model_dirty[req.addr] = 1'b1;
            if (model_responded.exists(req.addr)) begin
                late_store_count++;
            end
        end
    endtask

    task automatic record_ccu_request(input ccu_req_t req);
        ccu_rsp_t rsp;
        if (!model_data.exists(req.addr)) begin
            fail_run("CCU request for a line with no outstanding miss");
        end else if (model_requested[req.addr]) begin
            fail_run("Second CCU request for a line that was already requested");
        end else begin
            model_requested[req.addr] = 1'b1;
            ccu_count++;
            rsp.idx  = req.idx;
            rsp.data = ccu_pattern(req.addr);
            rsp_q.push_back(rsp);
            rsp_addr_q.push_back(req.addr);
            rsp_due_q.push_back(cycle + int'($urandom_range(12, 1)));
        end
    endtask

    task automatic retire_fill(input fill_t fill);
        if (!model_data.exists(fill.addr)) begin
            fail_run("Fill carries a line address that the model does not hold");
        end else if (!model_requested[fill.addr]) begin
            fail_run("Fill for a line that was never requested from the CCU");
        end else begin
            check_value("o_fill.data", CMP_WIDTH'(fill.data), CMP_WIDTH'(model_data[fill.addr]));
            check_value("o_fill.dirty", CMP_WIDTH'(fill.dirty), CMP_WIDTH'(model_dirty[fill.addr]));
            fill_count++;
            if (fill.dirty) begin
                dirty_fill_count++;
            end
            model_data.delete(fill.addr);
            model_dirty.delete(fill.addr);
            model_requested.delete(fill.addr);
            model_responded.delete(fill.addr);
        end
    endtask

    // Outputs are sampled at the falling edge where they have settled
    always @(negedge clk) begin : monitor
        logic exp_ready;
        lsu_fire_seen = 1'b0;
        if (!i_reset) begin
            // A fill that was held back last cycle must still be offered unchanged
            if (fill_hold) begin
                if (!o_fill_valid) begin
                    fail_run("Fill valid dropped before the cache took the fill");
                end else begin
                    check_value("o_fill", CMP_WIDTH'(o_fill), CMP_WIDTH'(held_fill));
                end
            end
            if (i_lsu_valid) begin
                exp_ready = expected_ready(i_lsu_req.addr);
                check_value("o_lsu_ready", CMP_WIDTH'(o_lsu_ready), CMP_WIDTH'(exp_ready));
                if (!exp_ready && !model_data.exists(i_lsu_req.addr)) begin
                    full_block_cycles++;
                end
            end
            if (o_ccu_req_valid && i_ccu_req_ready) begin
                record_ccu_request(o_ccu_req);
            end
            if (o_fill_valid && i_fill_ready) begin
                retire_fill(o_fill);
            end
            // Retiring first is safe since a line on the fill port is never accepted
            if (i_lsu_valid && o_lsu_ready) begin
                apply_request(i_lsu_req);
                lsu_fire_seen = 1'b1;
            end
            fill_hold = o_fill_valid && !i_fill_ready;
            held_fill = o_fill;
        end
    end

    // CCU and cache side with random back-pressure and delayed one-cycle responses
    always @(posedge clk) begin
        cycle++;
        i_ccu_req_ready <= ($urandom_range(3, 0) != 0);
        i_fill_ready    <= ($urandom_range(2, 0) == 0);
        if (!i_reset && (rsp_q.size() > 0) && (rsp_due_q[0] <= cycle)) begin
            i_ccu_rsp_valid <= 1'b1;
            i_ccu_rsp       <= rsp_q.pop_front();
            model_responded[rsp_addr_q.pop_front()] = 1'b1;
            void'(rsp_due_q.pop_front());
        end else begin
            i_ccu_rsp_valid <= 1'b0;
        end
    end

    task automatic wait_for_accept();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!lsu_fire_seen && (waited < ACCEPT_TIMEOUT));
        if (!lsu_fire_seen) begin
            fail_run("Timeout waiting for the DUT to accept an LSU request");
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (((model_data.num() != 0) || (rsp_q.size() != 0)) && (waited < DRAIN_TIMEOUT)) begin
            @(posedge clk);
            waited++;
        end
        if (model_data.num() != 0) begin
            fail_run("Timeout waiting for all outstanding lines to be filled");
        end
    endtask

    initial begin : main
        lsu_req_t req;
        clk               = 1'b0;
        i_reset           = 1'b1;
        i_lsu_valid       = 1'b0;
        i_lsu_req         = '0;
        i_ccu_req_ready   = 1'b0;
        i_ccu_rsp_valid   = 1'b0;
        i_ccu_rsp         = '0;
        i_fill_ready      = 1'b0;
        cycle             = 0;
        lsu_fire_seen     = 1'b0;
        fill_hold         = 1'b0;
        held_fill         = '0;
        alloc_count       = 0;
        ccu_count         = 0;
        fill_count        = 0;
        dirty_fill_count  = 0;
        full_block_cycles = 0;
        late_store_count  = 0;
        void'($urandom(SEED));
        pool[0] = 27'h0012340;
        pool[1] = 27'h00567a1;
        pool[2] = 27'h1abcd02;
        pool[3] = 27'h0000fe3;
        pool[4] = 27'h7f00184;
        pool[5] = 27'h03210c5;

        repeat (10) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_value("o_lsu_ready", CMP_WIDTH'(o_lsu_ready), CMP_WIDTH'(1'b1));
        check_value("o_ccu_req_valid", CMP_WIDTH'(o_ccu_req_valid), CMP_WIDTH'(1'b0));
        check_value("o_fill_valid", CMP_WIDTH'(o_fill_valid), CMP_WIDTH'(1'b0));
        @(posedge clk);

        for (int n = 0; n < NUM_REQUESTS; n++) begin
            // Idle gaps now and then let lines complete between bursts
            if ($urandom_range(3, 0) == 0) begin
                i_lsu_valid <= 1'b0;
                repeat ($urandom_range(3, 1)) @(posedge clk);
            end
            req = random_request();
            i_lsu_valid <= 1'b1;
            i_lsu_req   <= req;
            wait_for_accept();
        end
        i_lsu_valid <= 1'b0;
        wait_for_drain();

        // Every allocation needs exactly one CCU read and one fill
        check_value("ccu_count", CMP_WIDTH'(ccu_count), CMP_WIDTH'(alloc_count));
        check_value("fill_count", CMP_WIDTH'(fill_count), CMP_WIDTH'(alloc_count));

        // Each kind of line life has to have happened at least once
        if (fill_count == dirty_fill_count) begin
            fail_run("No line was filled after loads alone");
        end else if (dirty_fill_count == 0) begin
            fail_run("No line was filled with merged store data");
        end else if (full_block_cycles == 0) begin
            fail_run("A new line was never held off by a full queue");
        end else if (late_store_count == 0) begin
            fail_run("No store merged into a line after its CCU response");
        end else begin
            $display("Allocations %0d, dirty fills %0d, full queue stalls %0d, late stores %0d",
                     alloc_count, dirty_fill_count, full_block_cycles, late_store_count);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== mhq_top.sv ====
// Miss handling queue top level with the entry array, allocation, CCU request and fill blocks
`timescale 1ns/10ps
`default_nettype none

module mhq_top (
    input  logic                clk,
    input  logic                i_reset,

    // Load/store unit miss requests
    input  logic                i_lsu_valid,
    input  mhq_pkg::lsu_req_t   i_lsu_req,
    output logic                o_lsu_ready,

    // Line reads to the CCU
    output logic                o_ccu_req_valid,
    output mhq_pkg::ccu_req_t   o_ccu_req,
    input  logic                i_ccu_req_ready,

    // Line data back from the CCU
    input  logic                i_ccu_rsp_valid,
    input  mhq_pkg::ccu_rsp_t   i_ccu_rsp,

    // Completed lines to the cache
    output logic                o_fill_valid,
    output mhq_pkg::fill_t      o_fill,
    input  logic                i_fill_ready
);

    import mhq_pkg::*;

    lsu_req_t                    update;
    logic [MHQ_DEPTH-1:0]        update_en;
    logic [MHQ_DEPTH-1:0]        hits;
    logic [MHQ_DEPTH-1:0]        valids;
    logic [MHQ_DEPTH-1:0]        launching;
    logic [MHQ_DEPTH-1:0]        launched;
    mhq_entry_t [MHQ_DEPTH-1:0]  entries;

    for (genvar i = 0; i < MHQ_DEPTH; i++) begin : g_entry
        // The response tag selects which entry takes the returned line
        mhq_entry u_entry (
            .clk             (clk),
            .i_reset         (i_reset),
            .i_update_en     (update_en[i]),
            .i_update        (update),
            .i_ccu_done      (i_ccu_rsp_valid && (i_ccu_rsp.idx == MHQ_IDX_WIDTH'(i))),
            .i_ccu_data      (i_ccu_rsp.data),
            .i_fill_launched (launched[i]),
            .i_lookup_addr   (i_lsu_req.addr),
            .o_lookup_hit    (hits[i]),
            .o_entry         (entries[i])
        );

        assign valids[i] = entries[i].valid;
    end

    mhq_alloc u_alloc (
        .i_lsu_valid (i_lsu_valid),
        .i_lsu_req   (i_lsu_req),
        .i_hits      (hits),
        .i_valids    (valids),
        .i_launching (launching),
        .o_lsu_ready (o_lsu_ready),
        .o_update_en (update_en),
        .o_update    (update)
    );

    mhq_ccu_req u_ccu_req (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_entries       (entries),
        .i_ccu_req_ready (i_ccu_req_ready),
        .o_ccu_req_valid (o_ccu_req_valid),
        .o_ccu_req       (o_ccu_req)
    );

    mhq_fill u_fill (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_entries    (entries),
        .i_fill_ready (i_fill_ready),
        .o_fill_valid (o_fill_valid),
        .o_fill       (o_fill),
        .o_launching  (launching),
        .o_launched   (launched)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the miss handling queue testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module mhq_tb -f sources.f -o mhq_sim

./obj_dir/mhq_sim 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log" >&2
    exit 1
fi

// ==== sources.f ====
mhq_pkg.sv
mhq_entry.sv
mhq_alloc.sv
mhq_ccu_req.sv
mhq_fill.sv
mhq_top.sv
mhq_assert.sv
mhq_tb.sv
